// File: common/gf_consts.svh
/*
  Field configuration macros for the GF(2^8) arithmetic unit.
  Included by the packages and by every module that sizes logic from the field.
*/
`ifndef GF_CONSTS_SVH
`define GF_CONSTS_SVH

// Field width in bits
`define GF_M 8

// Low M bits of the field polynomial x^8 + x^4 + x^3 + x + 1
`define GF_POLY 8'h1B

// Width of an unreduced polynomial product
`define GF_PROD_W (2 * `GF_M - 1)

// Exponent that yields the multiplicative inverse, 2^M-2
`define GF_INV_EXP ((1 << `GF_M) - 2)

`endif

// File: common/gf_arith_pkg.sv
/*
  Field arithmetic types shared by the command path and the multiplier.
  Modules import this package to get the element type and the opcodes.
*/
`include "gf_consts.svh"

package gf_arith_pkg;

  // --------------------
  // Data types
  // --------------------

  // One field element, a polynomial of degree below M
  typedef logic [`GF_M-1:0] gf_elem_t;

  // Product of two elements before reduction
  typedef logic [`GF_PROD_W-1:0] gf_prod_t;

  // --------------------
  // Command opcodes
  // --------------------

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,  // a xor b
    OP_MUL = 3'd1,  // a times b
    OP_SQR = 3'd2,  // a squared
    OP_POW = 3'd3,  // a to the power b
    OP_INV = 3'd4   // inverse of a
  } gf_op_e;

endpackage

// File: common/gf_ctrl_pkg.sv
/*
  Control types for the exponentiation sequencer.
  Imported by the engine only.
*/
`include "gf_consts.svh"

package gf_ctrl_pkg;

  // --------------------
  // Engine FSM
  // --------------------

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,  // Waiting for go
    ST_SQUARE = 2'd1,  // Accumulator squared
    ST_MULT   = 2'd2,  // Accumulator times base
    ST_DONE   = 2'd3   // Finish strobe to result side
  } eng_state_e;

  // Index into the exponent, walks MSB down to bit 0
  typedef logic [$clog2(`GF_M)-1:0] exp_cnt_t;

endpackage

// File: gf_mul/gf_mul_classic.sv
/*
  Combinational GF(2^M) multiplier. Forms the full polynomial product with an
  AND array and XOR columns, then folds the upper bits back with a reduction
  matrix built at elaboration from the field polynomial.
*/
`include "gf_consts.svh"

`default_nettype none

module gf_mul_classic (
  input  gf_arith_pkg::gf_elem_t x0,
  input  gf_arith_pkg::gf_elem_t x1,
  output gf_arith_pkg::gf_elem_t y
);

  localparam int             M    = `GF_M;
  localparam int             PW   = `GF_PROD_W;
  localparam logic [M-1:0]   POLY = `GF_POLY;

  // One row per high product bit, row j is x^(M+j) mod f(x)
  typedef logic [M-2:0][M-1:0] red_mat_t;

  // --------------------
  // Reduction matrix
  // --------------------

  function automatic red_mat_t build_red_mat();
    red_mat_t mat;
    // x^M is congruent to the low polynomial bits
    mat[0] = POLY;
    // Each next row is the previous one times x, reduced once
    for (int j = 1; j < M - 1; j++) begin
      mat[j] = {mat[j-1][M-2:0], 1'b0} ^ (mat[j-1][M-1] ? POLY : '0);
    end
    return mat;
  endfunction

  localparam red_mat_t RED_MAT = build_red_mat();

  // --------------------
  // Polynomial product
  // --------------------

  // pp[i][j] is x0 bit j times x1 bit i
  logic [M-1:0][M-1:0] pp;
  logic [PW-1:0]       prod;

  // AND array
  always_comb begin
    for (int i = 0; i < M; i++) begin
      for (int j = 0; j < M; j++) begin
        pp[i][j] = x0[j] & x1[i];
      end
    end
  end

  // XOR columns, terms with equal degree i+j collapse into one bit
  always_comb begin
    prod = '0;
    for (int i = 0; i < M; i++) begin
      for (int j = 0; j < M; j++) begin
        prod[i+j] = prod[i+j] ^ pp[i][j];
      end
    end
  end

  // --------------------
  // Reduction
  // --------------------

  // Low bits pass straight, each set high bit adds its matrix row
  always_comb begin
    y = prod[M-1:0];
    for (int j = 0; j < M - 1; j++) begin
      y = y ^ (RED_MAT[j] & {M{prod[M+j]}});
    end
  end

endmodule

`default_nettype wire

// File: gf_mul/gf_exp_engine.sv
/*
  Exponentiation engine. Runs left-to-right square-and-multiply through one
  shared multiplier, or finishes ADD and MUL in a single cycle.
  Drives busy back to the command side and a finish strobe to the result side.
*/
`include "gf_consts.svh"

`default_nettype none

module gf_exp_engine (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   go,
  input  gf_arith_pkg::gf_elem_t base,
  input  gf_arith_pkg::gf_elem_t operand_b,
  input  logic [7:0]             exponent,
  input  logic                   add_mode,
  input  logic                   mul_mode,
  input  logic                   zero_inv,
  output logic                   busy,
  output logic                   fin,
  output gf_arith_pkg::gf_elem_t value,
  output logic                   base_zero_inv
);

  import gf_arith_pkg::*;
  import gf_ctrl_pkg::*;

  eng_state_e state;
  exp_cnt_t   bit_idx;
  gf_elem_t   acc;
  logic       zinv_r;

  gf_elem_t   mul_x0;
  gf_elem_t   mul_x1;
  gf_elem_t   mul_y;

  // --------------------
  // Shared multiplier
  // --------------------

  // Idle feeds the raw operands for a direct multiply
  always_comb begin
    mul_x0 = acc;
    mul_x1 = acc;
    case (state)
      ST_IDLE: begin
        mul_x0 = base;
        mul_x1 = operand_b;
      end
      ST_MULT: mul_x1 = base;
      default: mul_x1 = acc;
    endcase
  end

  gf_mul_classic u_mul (
    .x0 (mul_x0),
    .x1 (mul_x1),
    .y  (mul_y)
  );

  // --------------------
  // Sequencer FSM
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      bit_idx <= '0;
      acc     <= '0;
      zinv_r  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (go) begin
            zinv_r  <= zero_inv;
            bit_idx <= exp_cnt_t'(`GF_M - 1);
            if (add_mode) begin
              acc   <= base ^ operand_b;
              state <= ST_DONE;
            end else if (mul_mode) begin
              acc   <= mul_y;
              state <= ST_DONE;
            end else begin
              // Empty product, squaring 1 keeps it 1 until the first set bit
              acc   <= gf_elem_t'(1);
              state <= ST_SQUARE;
            end
          end
        end
        ST_SQUARE: begin
          acc <= mul_y;
          if (exponent[bit_idx]) begin
            state <= ST_MULT;
          end else if (bit_idx == '0) begin
            state <= ST_DONE;
          end else begin
            bit_idx <= bit_idx - 1'b1;
          end
        end
        ST_MULT: begin
          acc <= mul_y;
          if (bit_idx == '0) begin
            state <= ST_DONE;
          end else begin
            bit_idx <= bit_idx - 1'b1;
            state   <= ST_SQUARE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Busy covers the go cycle so the latch cannot take a second start
  assign busy          = go || (state != ST_IDLE);
  assign fin           = (state == ST_DONE);
  assign value         = acc;
  assign base_zero_inv = zinv_r;

  // A go that reaches a running sequencer would be lost
  assert property (@(posedge clk) disable iff (!rst_n) go |-> state == ST_IDLE);

endmodule

`default_nettype wire

// File: source/gf_cmd_latch.sv
/*
  Command input side. Accepts a start strobe while the engine is idle,
  latches the operands and decodes the opcode into base, exponent and mode.
*/
`include "gf_consts.svh"

`default_nettype none

module gf_cmd_latch (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  gf_arith_pkg::gf_op_e   op,
  input  gf_arith_pkg::gf_elem_t a,
  input  gf_arith_pkg::gf_elem_t b,
  input  logic                   busy,
  output logic                   go,
  output gf_arith_pkg::gf_elem_t base,
  output gf_arith_pkg::gf_elem_t operand_b,
  output logic [7:0]             exponent,
  output logic                   add_mode,
  output logic                   mul_mode,
  output logic                   zero_inv
);

  import gf_arith_pkg::*;

  logic       accept;
  logic [7:0] exp_dec;

  // Starts during a running command are dropped
  assign accept = start && !busy;

  // --------------------
  // Opcode decode
  // --------------------

  always_comb begin
    exp_dec = 8'd0;
    case (op)
      OP_MUL, OP_POW: exp_dec = 8'(b);
      OP_SQR:         exp_dec = 8'd2;
      OP_INV:         exp_dec = 8'(`GF_INV_EXP);
      default:        exp_dec = 8'd0;
    endcase
  end

  // Go strobe and mode flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      go       <= 1'b0;
      add_mode <= 1'b0;
      mul_mode <= 1'b0;
      zero_inv <= 1'b0;
    end else begin
      go <= accept;
      if (accept) begin
        add_mode <= (op == OP_ADD);
        mul_mode <= (op == OP_MUL);
        // Inverse of zero is flagged here, engine runs it anyway
        zero_inv <= (op == OP_INV) && (a == '0);
      end
    end
  end

  // Operands, held until the next accepted command
  always_ff @(posedge clk) begin
    if (accept) begin
      base      <= a;
      operand_b <= b;
      exponent  <= exp_dec;
    end
  end

  // Busy feedback must block a second go right behind the first
  assert property (@(posedge clk) disable iff (!rst_n) go |=> !go);

endmodule

`default_nettype wire

// File: source/gf_result_reg.sv
/*
  Result output side. Captures the engine value on fin, holds it until the
  next command completes and pulses done for one cycle.
*/
`default_nettype none

module gf_result_reg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fin,
  input  gf_arith_pkg::gf_elem_t value,
  input  logic                   base_zero_inv,
  output logic                   done,
  output gf_arith_pkg::gf_elem_t result,
  output logic                   zero_div
);

  import gf_arith_pkg::*;

  // --------------------
  // Output registers
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done     <= 1'b0;
      result   <= '0;
      zero_div <= 1'b0;
    end else begin
      // Done mirrors fin one cycle later
      done <= fin;
      if (fin) begin
        zero_div <= base_zero_inv;
        // Zero has no inverse, report 0
        if (base_zero_inv) begin
          result <= gf_elem_t'(0);
        end else begin
          result <= value;
        end
      end
    end
  end

  // Engine finish strobe is a single cycle, so done is too
  assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

endmodule

`default_nettype wire

// File: source/gf_alu_top.sv
/*
  Top level of the GF(2^8) arithmetic unit.
  Connects the command latch, the exponentiation engine and the result register.
*/
`default_nettype none

module gf_alu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  gf_arith_pkg::gf_op_e   op,
  input  gf_arith_pkg::gf_elem_t a,
  input  gf_arith_pkg::gf_elem_t b,
  output logic                   busy,
  output logic                   done,
  output gf_arith_pkg::gf_elem_t result,
  output logic                   zero_div
);

  import gf_arith_pkg::*;

  // --------------------
  // Latch to engine
  // --------------------

  logic       go;
  gf_elem_t   base;
  gf_elem_t   operand_b;
  logic [7:0] exponent;
  logic       add_mode;
  logic       mul_mode;
  logic       zero_inv;

  // Engine to result side
  logic       fin;
  gf_elem_t   value;
  logic       base_zero_inv;

  gf_cmd_latch u_cmd_latch (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .op        (op),
    .a         (a),
    .b         (b),
    .busy      (busy),
    .go        (go),
    .base      (base),
    .operand_b (operand_b),
    .exponent  (exponent),
    .add_mode  (add_mode),
    .mul_mode  (mul_mode),
    .zero_inv  (zero_inv)
  );

  gf_exp_engine u_exp_engine (
    .clk           (clk),
    .rst_n         (rst_n),
    .go            (go),
    .base          (base),
    .operand_b     (operand_b),
    .exponent      (exponent),
    .add_mode      (add_mode),
    .mul_mode      (mul_mode),
    .zero_inv      (zero_inv),
    .busy          (busy),
    .fin           (fin),
    .value         (value),
    .base_zero_inv (base_zero_inv)
  );

  gf_result_reg u_result_reg (
    .clk           (clk),
    .rst_n         (rst_n),
    .fin           (fin),
    .value         (value),
    .base_zero_inv (base_zero_inv),
    .done          (done),
    .result        (result),
    .zero_div      (zero_div)
  );

endmodule

`default_nettype wire

// File: testbench/gf_alu_tb.sv
/*
  Testbench for the GF(2^8) arithmetic unit. Issues ADD, MUL, SQR, POW and INV
  commands against a software field model; concurrent assertions do the checks.
*/
`include "gf_consts.svh"

module gf_alu_tb;

  import gf_arith_pkg::*;

  // Longest start to done distance for the exponent path
  localparam int MAX_LAT     = 2 * `GF_M + 3;
  // About 700 commands of up to 2*M+4 cycles, plus margin
  localparam int CYCLE_LIMIT = 16000;

  logic     clk;
  logic     rst_n;
  logic     start;
  gf_op_e   op;
  gf_elem_t a;
  gf_elem_t b;
  logic     busy;
  logic     done;
  gf_elem_t result;
  logic     zero_div;

  // Expected values, stored when a command is issued
  gf_elem_t exp_result;
  logic     exp_zdiv;
  logic     fixed_lat;
  logic     inv_chk;
  gf_elem_t inv_base;

  int value_errs;
  int proto_errs;
  int issued_cnt;
  int accepted_cnt;
  int done_cnt;
  int cycle_cnt;

  gf_alu_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .op       (op),
    .a        (a),
    .b        (b),
    .busy     (busy),
    .done     (done),
    .result   (result),
    .zero_div (zero_div)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Field model
  // --------------------

  // Shift-and-add multiply, x times alpha reduced by the field polynomial
  function automatic gf_elem_t gmul(input gf_elem_t x, input gf_elem_t y);
    gf_elem_t p;
    gf_elem_t s;
    logic     carry;
    p = '0;
    s = x;
    for (int i = 0; i < `GF_M; i++) begin
      if (y[i]) p = p ^ s;
      carry = s[`GF_M-1];
      s = s << 1;
      if (carry) s = s ^ `GF_POLY;
    end
    return p;
  endfunction

  // Power by repeated multiplication, e of 0 gives 1
  function automatic gf_elem_t gpow(input gf_elem_t x, input logic [7:0] e);
    gf_elem_t r;
    r = gf_elem_t'(1);
    for (int i = 0; i < int'(e); i++) begin
      r = gmul(r, x);
    end
    return r;
  endfunction

  // --------------------
  // Checks
  // --------------------

  check_reset: assert property (@(posedge clk) $rose(rst_n) |->
    (!busy && !done && !zero_div && result == '0))
    else begin
      value_errs++;
      $display("FAIL %0t: outputs not idle after reset", $time);
    end

  check_value: assert property (@(posedge clk) disable iff (!rst_n)
    done && !inv_chk |-> result == exp_result && zero_div == exp_zdiv)
    else begin
      value_errs++;
      $display("FAIL %0t: result %h zero_div %b, expected %h zero_div %b", $time,
               $sampled(result), $sampled(zero_div), exp_result, exp_zdiv);
    end

  // An inverse is right when the model product with the base is 1
  check_inverse: assert property (@(posedge clk) disable iff (!rst_n)
    done && inv_chk |-> gmul(inv_base, result) == gf_elem_t'(1) && !zero_div)
    else begin
      value_errs++;
      $display("FAIL %0t: inverse of %h gave %h zero_div %b", $time, inv_base,
               $sampled(result), $sampled(zero_div));
    end

  check_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !done |-> $stable(result))
    else begin
      value_errs++;
      $display("FAIL %0t: result changed without done", $time);
    end

  check_fixed_lat: assert property (@(posedge clk) disable iff (!rst_n)
    start && !busy && fixed_lat |-> ##1 !done ##1 !done ##1 done)
    else begin
      proto_errs++;
      $display("ADD or MUL done did not arrive exactly 3 cycles after start at %0t", $time);
    end

  check_var_lat: assert property (@(posedge clk) disable iff (!rst_n)
    start && !busy && !fixed_lat |-> ##[1:MAX_LAT] done)
    else begin
      proto_errs++;
      $display("Exponent command took longer than %0d cycles at %0t", MAX_LAT, $time);
    end

  check_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
    start && !busy |=> busy)
    else begin
      proto_errs++;
      $display("Busy did not rise after an accepted start at %0t", $time);
    end

  check_busy_fall: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
    else begin
      proto_errs++;
      $display("Busy still high while done pulsed at %0t", $time);
    end

  // Command and done counts, plus the run limit
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt++;
      if (start && !busy) accepted_cnt++;
      if (done) done_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
        $display("Timeout after %0d cycles, the run hung waiting for done", cycle_cnt);
        $display("Simulation finished: FAIL");
        $finish;
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  // Issue one command and wait for its done, optionally poking start while busy
  task automatic run_cmd(input gf_op_e cmd, input gf_elem_t x, input gf_elem_t y,
                         input logic intrude);
    gf_elem_t expect_val;
    expect_val = '0;
    case (cmd)
      OP_ADD:  expect_val = x ^ y;
      OP_MUL:  expect_val = gmul(x, y);
      OP_SQR:  expect_val = gpow(x, 8'd2);
      OP_POW:  expect_val = gpow(x, y);
      default: expect_val = '0;
    endcase
    @(negedge clk);
    start      = 1'b1;
    op         = cmd;
    a          = x;
    b          = y;
    exp_result = expect_val;
    exp_zdiv   = (cmd == OP_INV) && (x == '0);
    inv_chk    = (cmd == OP_INV) && (x != '0);
    inv_base   = x;
    fixed_lat  = (cmd == OP_ADD) || (cmd == OP_MUL);
    issued_cnt++;
    @(negedge clk);
    start = 1'b0;
    if (intrude) begin
      // Engine is running, this start must be dropped
      @(negedge clk);
      start = 1'b1;
      op    = OP_ADD;
      a     = ~x;
      @(negedge clk);
      start = 1'b0;
    end
    while (!done) @(negedge clk);
  endtask

  initial begin
    gf_elem_t edges [3];
    void'($urandom(32'hb070_cf7f));
    rst_n        = 1'b0;
    start        = 1'b0;
    op           = OP_ADD;
    a            = '0;
    b            = '0;
    exp_result   = '0;
    exp_zdiv     = 1'b0;
    fixed_lat    = 1'b0;
    inv_chk      = 1'b0;
    inv_base     = '0;
    value_errs   = 0;
    proto_errs   = 0;
    issued_cnt   = 0;
    accepted_cnt = 0;
    done_cnt     = 0;
    cycle_cnt    = 0;
    edges        = '{8'h00, 8'h01, 8'h80};
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Bitwise sum
    repeat (40) run_cmd(OP_ADD, 8'($urandom), 8'($urandom), 1'b0);

    // Multiply, edge pairs first
    foreach (edges[i]) begin
      foreach (edges[j]) run_cmd(OP_MUL, edges[i], edges[j], 1'b0);
    end
    repeat (200) run_cmd(OP_MUL, 8'($urandom), 8'($urandom), 1'b0);

    // Square and power, exponents 0 and 1 included
    run_cmd(OP_SQR, 8'h00, 8'h00, 1'b0);
    run_cmd(OP_SQR, 8'h01, 8'h00, 1'b0);
    repeat (40) run_cmd(OP_SQR, 8'($urandom), 8'($urandom), 1'b0);
    foreach (edges[i]) begin
      run_cmd(OP_POW, edges[i], 8'd0, 1'b0);
      run_cmd(OP_POW, edges[i], 8'd1, 1'b0);
    end
    run_cmd(OP_POW, 8'($urandom), 8'd0, 1'b0);
    run_cmd(OP_POW, 8'($urandom), 8'd1, 1'b0);
    repeat (100) run_cmd(OP_POW, 8'($urandom), 8'($urandom), 1'b0);

    // Inverse of every element, zero last
    for (int v = 1; v < 256; v++) run_cmd(OP_INV, 8'(v), 8'($urandom), 1'b0);
    run_cmd(OP_INV, 8'h00, 8'h00, 1'b0);

    // Starts during busy
    repeat (4) run_cmd(OP_POW, 8'($urandom), 8'($urandom), 1'b1);
    run_cmd(OP_INV, 8'($urandom) | 8'h01, 8'h00, 1'b1);

    repeat (4) @(negedge clk);
    check_counts: assert (accepted_cnt == issued_cnt && done_cnt == issued_cnt)
      else begin
        proto_errs++;
        $display("Issued %0d commands but %0d were accepted and %0d done pulses seen",
                 issued_cnt, accepted_cnt, done_cnt);
      end
    $display("Errors: %0d value, %0d protocol, %0d commands", value_errs, proto_errs,
             issued_cnt);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+common
common/gf_arith_pkg.sv
common/gf_ctrl_pkg.sv
gf_mul/gf_mul_classic.sv
gf_mul/gf_exp_engine.sv
source/gf_cmd_latch.sv
source/gf_result_reg.sv
source/gf_alu_top.sv
testbench/gf_alu_tb.sv

// File: Bender.yml
package:
  name: gf_alu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/gf_arith_pkg.sv
      - common/gf_ctrl_pkg.sv
      - gf_mul/gf_mul_classic.sv
      - gf_mul/gf_exp_engine.sv
      - source/gf_cmd_latch.sv
      - source/gf_result_reg.sv
      - source/gf_alu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/gf_alu_tb.sv
